// ==== Makefile ====
TOP = tb_threefish
OBJ = obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f threefish_top.f --top-module threefish_top
	verilator --lint-only --timing -f threefish_top.f --top-module $(TOP)

sim:
	verilator --binary --timing -f threefish_top.f --top-module $(TOP) --Mdir $(OBJ) -o sim
	./$(OBJ)/sim

clean:
	rm -rf $(OBJ)

// ==== hw/tf_key_schedule.sv ====
`default_nettype none

module tf_key_schedule (
	input wire clk_i,
	input wire rst_n_i,
	input wire load_i,
	input wire step_i,
	input wire threefish_pkg::tf_word_t [4:0] key_words_i,
	input wire threefish_pkg::tf_word_t [2:0] tweak_words_i,
	output threefish_pkg::tf_word_t [3:0] subkey_o
);

	import threefish_pkg::*;

	logic [2:0] key_base_q;
	logic [1:0] tweak_base_q;
	tf_subkey_idx_t idx_q;
	logic [2:0] key_base;
	logic [1:0] tweak_base;
	tf_subkey_idx_t idx;

	function automatic logic [2:0] wrap5(input logic [2:0] a, input logic [2:0] b);
		logic [3:0] sum;
		sum = {1'b0, a} + {1'b0, b};
		return (sum >= 4'd5) ? 3'(sum - 4'd5) : sum[2:0];
	endfunction

	function automatic logic [1:0] wrap3_next(input logic [1:0] a);
		return (a == 2'd2) ? 2'd0 : a + 2'd1;
	endfunction

	// subkey 0 is used in the load cycle, so the counters start at index 1.
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			key_base_q <= 3'd0;
			tweak_base_q <= 2'd0;
			idx_q <= '0;
		end else if (load_i) begin
			key_base_q <= 3'd1;
			tweak_base_q <= 2'd1;
			idx_q <= 5'd1;
		end else if (step_i) begin
			key_base_q <= wrap5(key_base_q, 3'd1);
			tweak_base_q <= wrap3_next(tweak_base_q);
			if (idx_q < tf_subkey_idx_t'(TF_NUM_SUBKEYS - 1)) begin
				idx_q <= idx_q + 5'd1;
			end
		end
	end

	assign key_base = load_i ? 3'd0 : key_base_q;
	assign tweak_base = load_i ? 2'd0 : tweak_base_q;
	assign idx = load_i ? 5'd0 : idx_q;

	always_comb begin
		for (int i = 0; i < TF_NUM_WORDS; i++) begin
			subkey_o[i] = key_words_i[wrap5(key_base, 3'(i))];
		end
		subkey_o[1] = subkey_o[1] + tweak_words_i[tweak_base];
		subkey_o[2] = subkey_o[2] + tweak_words_i[wrap3_next(tweak_base)];
		subkey_o[3] = subkey_o[3] + tf_word_t'(idx);
	end

endmodule

`default_nettype wire

// ==== hw/tf_load.sv ====
`default_nettype none

module tf_load (
	input wire clk_i,
	input wire rst_n_i,
	input wire start_i,
	input wire busy_i,
	input wire [255:0] key_i,
	input wire [127:0] tweak_i,
	input wire [255:0] plaintext_i,
	output logic load_o,
	output threefish_pkg::tf_word_t [4:0] key_words_o,
	output threefish_pkg::tf_word_t [2:0] tweak_words_o,
	output threefish_pkg::tf_word_t [3:0] pt_words_o
);

	import threefish_pkg::*;

	logic capture;

	// a start seen while a block is in flight is dropped.
	assign capture = start_i && !busy_i;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			load_o <= 1'b0;
		end else begin
			load_o <= capture;
		end
	end

	// words are little-endian, word 0 sits in the low 64 bits.
	always_ff @(posedge clk_i) begin
		if (capture) begin
			key_words_o[3:0] <= key_i;
			key_words_o[4] <= TF_KEY_PARITY ^ key_i[63:0] ^ key_i[127:64] ^
				key_i[191:128] ^ key_i[255:192];
			tweak_words_o[1:0] <= tweak_i;
			tweak_words_o[2] <= tweak_i[63:0] ^ tweak_i[127:64];
			pt_words_o <= plaintext_i;
		end
	end

endmodule

`default_nettype wire

// ==== hw/tf_mix_round.sv ====
`default_nettype none

module tf_mix_round (
	input wire clk_i,
	input wire rst_n_i,
	input wire init_i,
	input wire round_en_i,
	input wire inject_i,
	input wire threefish_pkg::tf_round_t round_i,
	input wire threefish_pkg::tf_word_t [3:0] pt_words_i,
	input wire threefish_pkg::tf_word_t [3:0] subkey_i,
	output threefish_pkg::tf_word_t [3:0] state_o
);

	import threefish_pkg::*;

	tf_word_t [3:0] state_q;
	tf_word_t [3:0] mixed;
	tf_word_t [3:0] permuted;
	logic [5:0] rot_a;
	logic [5:0] rot_b;

	function automatic tf_word_t rotl(input tf_word_t x, input logic [5:0] amt);
		return (x << amt) | (x >> (7'd64 - {1'b0, amt}));
	endfunction

	// the table repeats every eight rounds.
	assign rot_a = TF_ROT_TABLE[round_i[2:0]][0];
	assign rot_b = TF_ROT_TABLE[round_i[2:0]][1];

	// ****************************************
	// MIX pairs and permutation
	// ****************************************

	always_comb begin
		mixed[0] = state_q[0] + state_q[1];
		mixed[1] = rotl(state_q[1], rot_a) ^ mixed[0];
		mixed[2] = state_q[2] + state_q[3];
		mixed[3] = rotl(state_q[3], rot_b) ^ mixed[2];
	end

	// words 1 and 3 trade places, 0 and 2 stay.
	always_comb begin
		permuted[0] = mixed[0];
		permuted[1] = mixed[3];
		permuted[2] = mixed[2];
		permuted[3] = mixed[1];
	end

	// ****************************************
	// state register
	// ****************************************

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= '0;
		end else if (init_i) begin
			for (int i = 0; i < TF_NUM_WORDS; i++) begin
				state_q[i] <= pt_words_i[i] + subkey_i[i];
			end
		end else if (round_en_i) begin
			for (int i = 0; i < TF_NUM_WORDS; i++) begin
				state_q[i] <= inject_i ? permuted[i] + subkey_i[i] : permuted[i];
			end
		end
	end

	assign state_o = state_q;

endmodule

`default_nettype wire

// ==== hw/tf_output.sv ====
`default_nettype none

module tf_output (
	input wire clk_i,
	input wire rst_n_i,
	input wire finish_i,
	input wire threefish_pkg::tf_word_t [3:0] state_i,
	input wire threefish_pkg::tf_word_t [3:0] subkey_i,
	output logic done_o,
	output logic [255:0] ciphertext_o
);

	import threefish_pkg::*;

	tf_word_t [3:0] final_words;

	// the last subkey goes on after round 71.
	always_comb begin
		for (int i = 0; i < TF_NUM_WORDS; i++) begin
			final_words[i] = state_i[i] + subkey_i[i];
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			done_o <= 1'b0;
			ciphertext_o <= '0;
		end else begin
			done_o <= finish_i;
			if (finish_i) begin
				ciphertext_o <= final_words;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/tf_round_ctrl.sv ====
`default_nettype none

module tf_round_ctrl (
	input wire clk_i,
	input wire rst_n_i,
	input wire load_i,
	output logic busy_o,
	output logic init_o,
	output logic round_en_o,
	output logic inject_o,
	output logic step_o,
	output threefish_pkg::tf_round_t round_o,
	output logic finish_o
);

	import threefish_pkg::*;

	tf_state_e state_q;
	tf_round_t round_q;
	tf_round_t round_next;
	logic tail_q;

	assign round_next = round_q + 7'd1;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= TF_IDLE;
			round_q <= '0;
			tail_q <= 1'b0;
		end else begin
			// keeps busy high through the cycle in which done is shown.
			tail_q <= (state_q == TF_FINISH);
			case (state_q)
				TF_IDLE: begin
					if (load_i) begin
						state_q <= TF_ROUND;
						round_q <= '0;
					end
				end
				TF_ROUND, TF_INJECT: begin
					if (round_q == tf_round_t'(TF_NUM_ROUNDS - 1)) begin
						state_q <= TF_FINISH;
					end else begin
						round_q <= round_next;
						// every fourth round injects, the last subkey is left to the output side.
						if (round_next[1:0] == 2'b11 &&
							round_next != tf_round_t'(TF_NUM_ROUNDS - 1)) begin
							state_q <= TF_INJECT;
						end else begin
							state_q <= TF_ROUND;
						end
					end
				end
				TF_FINISH: begin
					state_q <= TF_IDLE;
				end
				default: begin
					state_q <= TF_IDLE;
				end
			endcase
		end
	end

	assign init_o = load_i && (state_q == TF_IDLE);
	assign round_en_o = (state_q == TF_ROUND) || (state_q == TF_INJECT);
	assign inject_o = (state_q == TF_INJECT);
	assign finish_o = (state_q == TF_FINISH);
	assign step_o = inject_o || finish_o;
	assign round_o = round_q;
	assign busy_o = load_i || (state_q != TF_IDLE) || tail_q;

endmodule

`default_nettype wire

// ==== hw/threefish_pkg.sv ====
`default_nettype none

package threefish_pkg;

	// ****************************************
	// block geometry
	// ****************************************

	// one Threefish word, four of them make a block.
	typedef logic [63:0] tf_word_t;

	localparam int TF_NUM_WORDS = 4;

	// ****************************************
	// round and subkey counts
	// ****************************************

	localparam int TF_NUM_ROUNDS = 72;

	// subkeys are numbered 0 to 18.
	localparam int TF_NUM_SUBKEYS = 19;

	typedef logic [6:0] tf_round_t;
	typedef logic [4:0] tf_subkey_idx_t;

	// seeds the fifth key word before the four key words are folded in.
	localparam tf_word_t TF_KEY_PARITY = 64'h1BD11BDAA9FC1A22;

	// ****************************************
	// rotation amounts
	// ****************************************

	// indexed by the round number modulo 8.
	// the first amount feeds the MIX on words 0 and 1, the second the MIX on words 2 and 3.
	localparam logic [5:0] TF_ROT_TABLE [8][2] = '{
		'{6'd14, 6'd16},
		'{6'd52, 6'd57},
		'{6'd23, 6'd40},
		'{6'd5,  6'd37},
		'{6'd25, 6'd33},
		'{6'd46, 6'd12},
		'{6'd58, 6'd22},
		'{6'd32, 6'd32}
	};

	// ****************************************
	// controller states
	// ****************************************

	typedef enum logic [1:0] {
		TF_IDLE,
		TF_INJECT,
		TF_ROUND,
		TF_FINISH
	} tf_state_e;

endpackage

`default_nettype wire

// ==== hw/threefish_top.sv ====
`default_nettype none

module threefish_top (
	input wire clk_i,
	input wire rst_n_i,
	input wire start_i,
	input wire [255:0] key_i,
	input wire [127:0] tweak_i,
	input wire [255:0] plaintext_i,
	output logic busy_o,
	output logic done_o,
	output logic [255:0] ciphertext_o
);

	import threefish_pkg::*;

	logic load_w;
	logic init_w;
	logic round_en_w;
	logic inject_w;
	logic step_w;
	logic finish_w;
	tf_round_t round_w;
	tf_word_t [4:0] key_words_w;
	tf_word_t [2:0] tweak_words_w;
	tf_word_t [3:0] pt_words_w;
	tf_word_t [3:0] subkey_w;
	tf_word_t [3:0] state_w;

	tf_load tf_load (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.start_i(start_i),
		.busy_i(busy_o),
		.key_i(key_i),
		.tweak_i(tweak_i),
		.plaintext_i(plaintext_i),
		.load_o(load_w),
		.key_words_o(key_words_w),
		.tweak_words_o(tweak_words_w),
		.pt_words_o(pt_words_w)
	);

	tf_key_schedule tf_key_schedule (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.load_i(load_w),
		.step_i(step_w),
		.key_words_i(key_words_w),
		.tweak_words_i(tweak_words_w),
		.subkey_o(subkey_w)
	);

	tf_round_ctrl tf_round_ctrl (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.load_i(load_w),
		.busy_o(busy_o),
		.init_o(init_w),
		.round_en_o(round_en_w),
		.inject_o(inject_w),
		.step_o(step_w),
		.round_o(round_w),
		.finish_o(finish_w)
	);

	tf_mix_round tf_mix_round (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.init_i(init_w),
		.round_en_i(round_en_w),
		.inject_i(inject_w),
		.round_i(round_w),
		.pt_words_i(pt_words_w),
		.subkey_i(subkey_w),
		.state_o(state_w)
	);

	tf_output tf_output (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.finish_i(finish_w),
		.state_i(state_w),
		.subkey_i(subkey_w),
		.done_o(done_o),
		.ciphertext_o(ciphertext_o)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`default_nettype none

module tb_clock (
	output logic clk_o
);

	// one full period every 4 time units.
	initial begin
		clk_o = 1'b0;
	end

	always begin
		#2 clk_o = ~clk_o;
	end

endmodule

`default_nettype wire

// ==== testbench/tb_threefish.sv ====
`default_nettype none

module tb_threefish;

	logic clk;
	logic rst_n;
	logic start;
	logic [255:0] key;
	logic [127:0] tweak;
	logic [255:0] plaintext;
	logic busy;
	logic done;
	logic [255:0] ciphertext;

	logic [255:0] expect_q[$];
	string name_q[$];
	int issued = 0;
	int completed = 0;
	logic [31:0] seed = 32'ha94b;

	tb_clock clk_gen (
		.clk_o(clk)
	);

	threefish_top dut0 (
		.clk_i(clk),
		.rst_n_i(rst_n),
		.start_i(start),
		.key_i(key),
		.tweak_i(tweak),
		.plaintext_i(plaintext),
		.busy_o(busy),
		.done_o(done),
		.ciphertext_o(ciphertext)
	);

	// ****************************************
	// reference model
	// ****************************************

	function automatic logic [63:0] rotate_left(input logic [63:0] x, input int n);
		return (x << n) | (x >> (64 - n));
	endfunction

	function automatic int rot_amount(input int r, input bit second);
		case (r % 8)
			0: return second ? 16 : 14;
			1: return second ? 57 : 52;
			2: return second ? 40 : 23;
			3: return second ? 37 : 5;
			4: return second ? 33 : 25;
			5: return second ? 12 : 46;
			6: return second ? 22 : 58;
			default: return 32;
		endcase
	endfunction

	// word 4 is the parity word.
	function automatic logic [63:0] key_word(input logic [255:0] k, input int j);
		case (j)
			0: return k[63:0];
			1: return k[127:64];
			2: return k[191:128];
			3: return k[255:192];
			default: return 64'h1BD11BDAA9FC1A22 ^ k[63:0] ^ k[127:64] ^ k[191:128] ^ k[255:192];
		endcase
	endfunction

	function automatic logic [63:0] tweak_word(input logic [127:0] t, input int j);
		case (j)
			0: return t[63:0];
			1: return t[127:64];
			default: return t[63:0] ^ t[127:64];
		endcase
	endfunction

	function automatic logic [63:0] subkey_word(input logic [255:0] k, input logic [127:0] t,
		input int s, input int i);
		logic [63:0] w;
		w = key_word(k, (s + i) % 5);
		if (i == 1) begin
			w = w + tweak_word(t, s % 3);
		end else if (i == 2) begin
			w = w + tweak_word(t, (s + 1) % 3);
		end else if (i == 3) begin
			w = w + 64'(s);
		end
		return w;
	endfunction

	function automatic logic [255:0] threefish_encrypt(input logic [255:0] k,
		input logic [127:0] t, input logic [255:0] p);
		logic [63:0] v0, v1, v2, v3;
		logic [63:0] m0, m1, m2, m3;
		int r;
		v0 = p[63:0] + subkey_word(k, t, 0, 0);
		v1 = p[127:64] + subkey_word(k, t, 0, 1);
		v2 = p[191:128] + subkey_word(k, t, 0, 2);
		v3 = p[255:192] + subkey_word(k, t, 0, 3);
		for (r = 0; r < 72; r++) begin
			m0 = v0 + v1;
			m1 = rotate_left(v1, rot_amount(r, 1'b0)) ^ m0;
			m2 = v2 + v3;
			m3 = rotate_left(v3, rot_amount(r, 1'b1)) ^ m2;
			v0 = m0;
			v1 = m3;
			v2 = m2;
			v3 = m1;
			// after round 71 this adds subkey 18, the final one.
			if ((r + 1) % 4 == 0) begin
				v0 = v0 + subkey_word(k, t, (r + 1) / 4, 0);
				v1 = v1 + subkey_word(k, t, (r + 1) / 4, 1);
				v2 = v2 + subkey_word(k, t, (r + 1) / 4, 2);
				v3 = v3 + subkey_word(k, t, (r + 1) / 4, 3);
			end
		end
		return {v3, v2, v1, v0};
	endfunction

	// ****************************************
	// helpers
	// ****************************************

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic random_bits(output logic [255:0] v);
		int i;
		v = '0;
		for (i = 0; i < 8; i++) begin
			seed = lcg_next(seed);
			v = {v[223:0], seed};
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_block(input string name, input logic [255:0] expected,
		input logic [255:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("error %s: expected %h, actual %h", name, expected, actual));
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			abort_run($sformatf("error %s: expected %b, actual %b", name, expected, actual));
		end
	endtask

	// called on a falling edge, the next rising edge samples the start.
	task automatic issue_block(input logic [255:0] blk_key, input logic [127:0] blk_tweak,
		input logic [255:0] blk_pt, input bit expect_result, input string name);
		int n;
		n = 0;
		while (busy && n < 200) begin
			@(negedge clk);
			n++;
		end
		if (busy) begin
			abort_run("timeout: busy_o did not fall before a new start");
		end
		key = blk_key;
		tweak = blk_tweak;
		plaintext = blk_pt;
		start = 1'b1;
		if (expect_result) begin
			expect_q.push_back(threefish_encrypt(blk_key, blk_tweak, blk_pt));
			name_q.push_back(name);
			issued++;
		end
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic wait_completed();
		int n;
		n = 0;
		while (completed < issued && n < 300) begin
			@(negedge clk);
			n++;
		end
		if (completed < issued) begin
			abort_run("timeout: a block result was not compared within 300 cycles");
		end
	endtask

	// ****************************************
	// result comparison
	// ****************************************

	initial begin : compare_results
		int n;
		logic [255:0] expected;
		string block_name;
		forever begin
			@(negedge clk);
			if (expect_q.size() > 0) begin
				n = 0;
				while (!done && n < 200) begin
					@(negedge clk);
					n++;
				end
				if (!done) begin
					abort_run("timeout: done_o did not rise within 200 cycles of a start");
				end else begin
					expected = expect_q.pop_front();
					block_name = name_q.pop_front();
					check_block(block_name, expected, ciphertext);
					completed++;
				end
			end else if (done) begin
				abort_run("done_o pulsed while no block was in flight");
			end
		end
	end

	// ****************************************
	// test sequence
	// ****************************************

	initial begin
		int i;
		int k;
		logic [255:0] r_key;
		logic [255:0] r_tweak;
		logic [255:0] r_pt;
		logic [255:0] held;
		rst_n = 1'b0;
		start = 1'b0;
		key = '0;
		tweak = '0;
		plaintext = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_bit("reset busy", 1'b0, busy);
		check_bit("reset done", 1'b0, done);
		check_block("reset ciphertext", 256'd0, ciphertext);

		// all-zero block, done must rise on the 74th edge after the start edge.
		issue_block(256'd0, 128'd0, 256'd0, 1'b1, "zero block");
		for (k = 0; k <= 75; k++) begin
			check_bit($sformatf("done after edge %0d", k), k == 74, done);
			check_bit($sformatf("busy after edge %0d", k), k <= 74, busy);
			if (k < 75) begin
				@(negedge clk);
			end
		end
		wait_completed();

		for (i = 0; i < 20; i++) begin
			random_bits(r_key);
			random_bits(r_tweak);
			random_bits(r_pt);
			issue_block(r_key, r_tweak[127:0], r_pt, 1'b1, $sformatf("random block %0d", i));
			wait_completed();
		end

		// a second start in flight must not disturb the first block.
		random_bits(r_key);
		random_bits(r_tweak);
		random_bits(r_pt);
		issue_block(r_key, r_tweak[127:0], r_pt, 1'b1, "start while busy");
		repeat (10) @(negedge clk);
		check_bit("busy at second start", 1'b1, busy);
		random_bits(key);
		random_bits(plaintext);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		wait_completed();

		held = ciphertext;
		for (k = 0; k < 100; k++) begin
			@(negedge clk);
			check_block("result hold", held, ciphertext);
			check_bit("no done after ignored start", 1'b0, done);
		end

		random_bits(r_key);
		random_bits(r_tweak);
		random_bits(r_pt);
		issue_block(r_key, r_tweak[127:0], r_pt, 1'b0, "");
		// the previous result stays visible while the next block runs.
		for (k = 0; k < 30; k++) begin
			@(negedge clk);
			check_block("result hold in flight", held, ciphertext);
		end
		check_bit("busy mid block", 1'b1, busy);
		rst_n = 1'b0;
		@(negedge clk);
		check_bit("busy after reset", 1'b0, busy);
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		check_block("ciphertext after reset", 256'd0, ciphertext);
		for (k = 0; k < 100; k++) begin
			@(negedge clk);
			check_bit("no done after reset", 1'b0, done);
			check_bit("idle after reset", 1'b0, busy);
		end

		// the engine must work again once reset is released.
		random_bits(r_key);
		random_bits(r_tweak);
		random_bits(r_pt);
		issue_block(r_key, r_tweak[127:0], r_pt, 1'b1, "block after reset");
		wait_completed();

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== threefish_top.f ====
hw/threefish_pkg.sv
hw/tf_load.sv
hw/tf_key_schedule.sv
hw/tf_round_ctrl.sv
hw/tf_mix_round.sv
hw/tf_output.sv
hw/threefish_top.sv
testbench/tb_clock.sv
testbench/tb_threefish.sv
